// ==== Makefile ====
# Verilator build for the execute unit testbench

VERILATOR ?= verilator
TOP       ?= exu_tb
RTL_TOP   ?= exu_top
FILELIST  ?= exu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== exu.f ====
src/exu_pkg.sv
src/exu_md_if.sv
src/exu_alu.sv
src/exu_multiplier.sv
src/exu_cmd_queue.sv
src/exu_ctrl.sv
src/exu_top.sv
verif/exu_tb.sv

// ==== src/exu_alu.sv ====
// integer ALU
// adder, shifter, comparator and result mux; the adder is shared
// with the multiplier through the md link

`timescale 1ns/10ps

module exu_alu import exu_pkg::*; (
  input  exu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  exu_md_if.alu           md,
  output logic [XLEN-1:0] result_o,
  output logic            comparison_result_o
);

  localparam int SHAMT_W = $clog2(XLEN);

  logic [XLEN-1:0] operand_a_rev;

  // a reversed, left shift reuses the right shifter
  for (genvar k = 0; k < XLEN; k++) begin : gen_rev_a
    assign operand_a_rev[k] = operand_a_i[XLEN-1-k];
  end

  ////////////////////
  // adder
  ////////////////////

  logic            adder_negate_b;
  logic [XLEN:0]   operand_b_neg;
  logic [XLEN:0]   adder_in_a;
  logic [XLEN:0]   adder_in_b;
  logic [XLEN-1:0] adder_result;

  // subtract and all compares use a - b
  always_comb begin
    adder_negate_b = 1'b0;
    if (operator_i == EXU_SUB || is_cmp_op(operator_i)) begin
      adder_negate_b = 1'b1;
    end
  end

  // low bit 1 on a plus inverted b gives the +1 of two's complement
  assign operand_b_neg = {operand_b_i, 1'b0} ^ {(XLEN+1){adder_negate_b}};

  // multiplier takes over the adder while md_en
  assign adder_in_a = md.md_en ? md.md_operand_a : {operand_a_i, 1'b1};
  assign adder_in_b = md.md_en ? md.md_operand_b : operand_b_neg;

  assign md.adder_result_ext = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  // drop the padding bit
  assign adder_result        = md.adder_result_ext[XLEN:1];

  ////////////////////
  // shifter
  ////////////////////

  logic                shift_left;
  logic                shift_arith;
  logic [SHAMT_W-1:0]  shift_amt;
  logic [XLEN-1:0]     shift_op_a;
  logic signed [XLEN:0] shift_right_ext;
  logic [XLEN-1:0]     shift_right_result;
  logic [XLEN-1:0]     shift_left_result;
  logic [XLEN-1:0]     shift_result;

  assign shift_amt   = operand_b_i[SHAMT_W-1:0];
  assign shift_left  = (operator_i == EXU_SLL);
  assign shift_arith = (operator_i == EXU_SRA);
  assign shift_op_a  = shift_left ? operand_a_rev : operand_a_i;

  // extra top bit: sign for sra, zero otherwise
  assign shift_right_ext    = $signed({shift_arith & shift_op_a[XLEN-1], shift_op_a}) >>>
                              shift_amt;
  assign shift_right_result = shift_right_ext[XLEN-1:0];

  // reverse back for left shifts
  for (genvar j = 0; j < XLEN; j++) begin : gen_rev_shift
    assign shift_left_result[j] = shift_right_result[XLEN-1-j];
  end

  assign shift_result = shift_left ? shift_left_result : shift_right_result;

  ////////////////////
  // comparator
  ////////////////////

  logic cmp_signed;
  logic is_equal;
  logic is_greater_equal;
  logic cmp_result;

  assign cmp_signed = operator_i inside {EXU_GE, EXU_LT, EXU_SLT, EXU_SLET};
  assign is_equal   = (adder_result == '0);

  // same msb: sign of the difference decides
  // differing msb: a's msb, flipped for signed forms
  always_comb begin
    if (operand_a_i[XLEN-1] == operand_b_i[XLEN-1]) begin
      is_greater_equal = ~adder_result[XLEN-1];
    end else begin
      is_greater_equal = operand_a_i[XLEN-1] ^ cmp_signed;
    end
  end

  always_comb begin
    cmp_result = is_equal;
    unique case (operator_i)
      EXU_EQ:                       cmp_result = is_equal;
      EXU_NE:                       cmp_result = ~is_equal;
      EXU_GE, EXU_GEU:              cmp_result = is_greater_equal;
      EXU_LT, EXU_LTU,
      EXU_SLT, EXU_SLTU:            cmp_result = ~is_greater_equal;
      EXU_SLET, EXU_SLETU:          cmp_result = ~is_greater_equal | is_equal;
      default: ;
    endcase
  end

  assign comparison_result_o = cmp_result;

  ////////////////////
  // result mux
  ////////////////////

  always_comb begin
    result_o = '0;
    unique case (operator_i)
      EXU_AND:                      result_o = operand_a_i & operand_b_i;
      EXU_OR:                       result_o = operand_a_i | operand_b_i;
      EXU_XOR:                      result_o = operand_a_i ^ operand_b_i;
      EXU_ADD, EXU_SUB:             result_o = adder_result;
      EXU_SLL, EXU_SRL, EXU_SRA:    result_o = shift_result;
      EXU_LT, EXU_LTU, EXU_GE, EXU_GEU, EXU_EQ, EXU_NE,
      EXU_SLT, EXU_SLTU, EXU_SLET, EXU_SLETU: begin
        // compare bit zero-extended
        result_o = {{(XLEN-1){1'b0}}, cmp_result};
      end
      // mul result comes from the multiplier
      default: ;
    endcase
  end

endmodule

// ==== src/exu_cmd_queue.sv ====
// command queue
// circular FIFO of commands, one input credit returned per pop

`timescale 1ns/10ps

module exu_cmd_queue import exu_pkg::*; #(
  parameter int CMD_DEPTH = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  exu_cmd_t push_cmd_i,
  input  logic     pop_i,
  output logic     valid_o,
  output exu_cmd_t cmd_o,
  output logic     credit_o
);

  localparam int PTR_W = $clog2(CMD_DEPTH);

  exu_cmd_t         mem_q [CMD_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             pop;
  logic             credit_q;

  // sender credits keep the queue from overflowing
  assign valid_o = (count_q != '0);
  assign pop     = pop_i & valid_o;
  assign cmd_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      // pointers wrap, depth is a power of two
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q  <= count_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop);
      // one credit back per freed entry
      credit_q <= pop;
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= push_cmd_i;
  end

  assign credit_o = credit_q;

endmodule

// ==== src/exu_ctrl.sv ====
// issue control
// pops one command at a time, sequences multiplies, tracks output
// credits and registers the result

`timescale 1ns/10ps

module exu_ctrl import exu_pkg::*; #(
  parameter int RES_CREDITS = 2
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // queue side
  input  logic            q_valid_i,
  input  exu_cmd_t        q_cmd_i,
  output logic            q_pop_o,
  // alu side
  output exu_op_e         alu_op_o,
  output logic [XLEN-1:0] alu_a_o,
  output logic [XLEN-1:0] alu_b_o,
  input  logic [XLEN-1:0] alu_result_i,
  input  logic            alu_cmp_i,
  // multiplier side
  output logic            mul_start_o,
  input  logic            mul_done_i,
  input  logic [XLEN-1:0] mul_result_i,
  // result port
  input  logic            res_credit_i,
  output logic            res_valid_o,
  output exu_res_t        res_o
);

  localparam int CNT_W = $clog2(RES_CREDITS + 1);

  logic             mul_busy_q;
  logic [CNT_W-1:0] credit_q;
  logic             issue_mul;
  logic             res_valid_q;
  // payload
  exu_res_t         res_q;
  logic [TAG_W-1:0] mul_tag_q;

  ////////////////////
  // issue
  ////////////////////

  // credit is taken at pop so a result never waits
  assign q_pop_o     = ~mul_busy_q & q_valid_i & (credit_q != '0);
  assign issue_mul   = q_pop_o & is_mul_op(q_cmd_i.op);
  assign mul_start_o = issue_mul;

  // queue head is the issued command in the pop cycle
  assign alu_op_o = q_cmd_i.op;
  assign alu_a_o  = q_cmd_i.a;
  assign alu_b_o  = q_cmd_i.b;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mul_busy_q  <= 1'b0;
      credit_q    <= CNT_W'(RES_CREDITS);
      res_valid_q <= 1'b0;
    end else begin
      // idle <-> multiply busy
      if (issue_mul) begin
        mul_busy_q <= 1'b1;
      end else if (mul_done_i) begin
        mul_busy_q <= 1'b0;
      end
      // returned credit vs credit taken
      unique case ({res_credit_i, q_pop_o})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: ;
      endcase
      res_valid_q <= (q_pop_o & ~issue_mul) | mul_done_i;
    end
  end

  ////////////////////
  // result register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (issue_mul) begin
      mul_tag_q <= q_cmd_i.tag;
    end
    if (q_pop_o && !issue_mul) begin
      res_q.data <= alu_result_i;
      // cmp bit only meaningful for compares
      res_q.cmp  <= is_cmp_op(q_cmd_i.op) & alu_cmp_i;
      res_q.tag  <= q_cmd_i.tag;
    end else if (mul_done_i) begin
      res_q.data <= mul_result_i;
      res_q.cmp  <= 1'b0;
      res_q.tag  <= mul_tag_q;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

endmodule

// ==== src/exu_md_if.sv ====
// multiplier to ALU adder link
// multiplier borrows the ALU adder, operands in and 34-bit sum out

`timescale 1ns/10ps

interface exu_md_if import exu_pkg::*; ();

  // adder override, operands carry a low padding bit
  logic            md_en;
  logic [XLEN:0]   md_operand_a;
  logic [XLEN:0]   md_operand_b;
  // raw adder sum incl. carry out
  logic [XLEN+1:0] adder_result_ext;

  modport mult (output md_en, md_operand_a, md_operand_b, input adder_result_ext);

  modport alu (input md_en, md_operand_a, md_operand_b, output adder_result_ext);

endinterface

// ==== src/exu_multiplier.sv ====
// iterative shift-and-add multiplier
// low XLEN bits of the product in XLEN steps, adds go through the ALU adder

`timescale 1ns/10ps

module exu_multiplier import exu_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            start_i,
  input  logic [XLEN-1:0] multiplicand_i,
  input  logic [XLEN-1:0] multiplier_i,
  exu_md_if.mult          md,
  output logic            done_o,
  output logic [XLEN-1:0] product_o
);

  localparam int CNT_W = $clog2(XLEN);

  logic             busy_q;
  logic             done_q;
  logic [CNT_W-1:0] step_q;
  // datapath registers
  logic [XLEN-1:0]  acc_q;
  logic [XLEN-1:0]  mcand_q;
  logic [XLEN-1:0]  mplier_q;
  logic             last_step;

  assign last_step = (step_q == CNT_W'(XLEN - 1));

  // borrow the adder only when the current multiplier bit is set
  assign md.md_en        = busy_q & mplier_q[0];
  // zero pad bit, sum sits in [XLEN:1]
  assign md.md_operand_a = {acc_q, 1'b0};
  assign md.md_operand_b = {mcand_q, 1'b0};

  // step control
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        step_q <= '0;
      end else if (busy_q) begin
        step_q <= step_q + 1'b1;
        if (last_step) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // accumulate and shift
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      acc_q    <= '0;
      mcand_q  <= multiplicand_i;
      mplier_q <= multiplier_i;
    end else if (busy_q) begin
      if (mplier_q[0]) begin
        acc_q <= md.adder_result_ext[XLEN:1];
      end
      // high bits fall off, only the low product is kept
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign done_o    = done_q;
  assign product_o = acc_q;

endmodule

// ==== src/exu_pkg.sv ====
// execute unit package
// operation encoding, data and tag widths, command and result words

package exu_pkg;

  // data path width
  parameter int XLEN  = 32;
  // command tag width
  parameter int TAG_W = 4;

  // operation codes, ALU set plus multiply
  typedef enum logic [4:0] {
    EXU_ADD   = 5'd0,
    EXU_SUB   = 5'd1,
    EXU_XOR   = 5'd2,
    EXU_OR    = 5'd3,
    EXU_AND   = 5'd4,
    EXU_SLL   = 5'd5,
    EXU_SRL   = 5'd6,
    EXU_SRA   = 5'd7,
    EXU_LT    = 5'd8,
    EXU_LTU   = 5'd9,
    EXU_GE    = 5'd10,
    EXU_GEU   = 5'd11,
    EXU_EQ    = 5'd12,
    EXU_NE    = 5'd13,
    EXU_SLT   = 5'd14,
    EXU_SLTU  = 5'd15,
    EXU_SLET  = 5'd16,
    EXU_SLETU = 5'd17,
    EXU_MUL   = 5'd18
  } exu_op_e;

  // queue entry and issued command, 73 bits
  typedef struct packed {
    exu_op_e               op;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [TAG_W-1:0]      tag;
  } exu_cmd_t;

  // registered result, 37 bits
  typedef struct packed {
    logic [XLEN-1:0]       data;
    logic                  cmp;
    logic [TAG_W-1:0]      tag;
  } exu_res_t;

  // true for ops that produce a comparison bit
  function automatic logic is_cmp_op(exu_op_e op);
    return op inside {EXU_LT, EXU_LTU, EXU_GE, EXU_GEU, EXU_EQ, EXU_NE,
                      EXU_SLT, EXU_SLTU, EXU_SLET, EXU_SLETU};
  endfunction

  // multi-cycle ops
  function automatic logic is_mul_op(exu_op_e op);
    return op == EXU_MUL;
  endfunction

endpackage

// ==== src/exu_top.sv ====
// integer execute unit top
// credit-based command input, command queue, issue control, ALU and
// shared-adder multiplier, credit-based result output

`timescale 1ns/10ps

module exu_top import exu_pkg::*; #(
  parameter int CMD_DEPTH   = 4,
  parameter int RES_CREDITS = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // command port
  input  logic             cmd_valid_i,
  input  exu_op_e          cmd_op_i,
  input  logic [XLEN-1:0]  cmd_a_i,
  input  logic [XLEN-1:0]  cmd_b_i,
  input  logic [TAG_W-1:0] cmd_tag_i,
  output logic             cmd_credit_o,
  // result port
  output logic             res_valid_o,
  output logic [XLEN-1:0]  res_data_o,
  output logic             res_cmp_o,
  output logic [TAG_W-1:0] res_tag_o,
  input  logic             res_credit_i
);

  exu_cmd_t        push_cmd;
  logic            q_valid;
  exu_cmd_t        q_cmd;
  logic            q_pop;
  exu_op_e         alu_op;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;
  logic            mul_start;
  logic            mul_done;
  logic [XLEN-1:0] mul_result;
  exu_res_t        res;

  // shared adder link
  exu_md_if md ();

  assign push_cmd = '{op: cmd_op_i, a: cmd_a_i, b: cmd_b_i, tag: cmd_tag_i};

  exu_cmd_queue #(
    .CMD_DEPTH (CMD_DEPTH)
  ) u_queue (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .push_i     (cmd_valid_i),
    .push_cmd_i (push_cmd),
    .pop_i      (q_pop),
    .valid_o    (q_valid),
    .cmd_o      (q_cmd),
    .credit_o   (cmd_credit_o)
  );

  exu_ctrl #(
    .RES_CREDITS (RES_CREDITS)
  ) u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .q_valid_i    (q_valid),
    .q_cmd_i      (q_cmd),
    .q_pop_o      (q_pop),
    .alu_op_o     (alu_op),
    .alu_a_o      (alu_a),
    .alu_b_o      (alu_b),
    .alu_result_i (alu_result),
    .alu_cmp_i    (alu_cmp),
    .mul_start_o  (mul_start),
    .mul_done_i   (mul_done),
    .mul_result_i (mul_result),
    .res_credit_i (res_credit_i),
    .res_valid_o  (res_valid_o),
    .res_o        (res)
  );

  exu_alu u_alu (
    .operator_i          (alu_op),
    .operand_a_i         (alu_a),
    .operand_b_i         (alu_b),
    .md                  (md.alu),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp)
  );

  // operands come from the issued command in the start cycle
  exu_multiplier u_mult (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .start_i        (mul_start),
    .multiplicand_i (alu_a),
    .multiplier_i   (alu_b),
    .md             (md.mult),
    .done_o         (mul_done),
    .product_o      (mul_result)
  );

  assign res_data_o = res.data;
  assign res_cmp_o  = res.cmp;
  assign res_tag_o  = res.tag;

endmodule

// ==== verif/exu_tb.sv ====
// execute unit testbench
// credit-driven command sender, reference model and in-order result checker

`timescale 1ns/10ps

module exu_tb import exu_pkg::*; ();

  localparam int CMD_DEPTH      = 4;
  localparam int RES_CREDITS    = 2;
  localparam int BP_TOTAL       = CMD_DEPTH + RES_CREDITS + 3;
  // commands per test: 14 directed, 40 compares, 57 mul, 200 mix, bp
  localparam int NUM_CMDS       = 14 + 40 + 57 + 200 + BP_TOTAL;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * 40 + 500;

  logic             clk = 1'b0;
  logic             rst_n_i;
  logic             cmd_valid_i;
  exu_op_e          cmd_op_i;
  logic [XLEN-1:0]  cmd_a_i;
  logic [XLEN-1:0]  cmd_b_i;
  logic [TAG_W-1:0] cmd_tag_i;
  logic             cmd_credit_o;
  logic             res_valid_o;
  logic [XLEN-1:0]  res_data_o;
  logic             res_cmp_o;
  logic [TAG_W-1:0] res_tag_o;
  logic             res_credit_i = 1'b0;

  // bookkeeping
  exu_res_t         exp_q [$];
  int               sent_count      = 0;
  int               returned_count  = 0;
  int               max_outstanding = 0;
  int               res_count       = 0;
  int               pending_credits = 0;
  logic             hold_credits    = 1'b0;
  logic [TAG_W-1:0] tag_ctr         = '0;
  int               errors          = 0;
  int               test_errors     = 0;
  int               checks          = 0;
  int               test_count      = 0;
  string            cur_test        = "reset";
  integer           seed            = 41;

  exu_op_e     cmp_ops [10] = '{EXU_LT, EXU_LTU, EXU_GE, EXU_GEU, EXU_EQ,
                                EXU_NE, EXU_SLT, EXU_SLTU, EXU_SLET, EXU_SLETU};
  // signed/unsigned edge pairs
  logic [31:0] pair_a [4]   = '{32'h8000_0000, 32'h7FFF_FFFF, 32'h1234_5678, 32'h0000_0005};
  logic [31:0] pair_b [4]   = '{32'h7FFF_FFFF, 32'h8000_0000, 32'h1234_5678, 32'h8000_0005};

  always #2 clk = ~clk;

  exu_top #(
    .CMD_DEPTH   (CMD_DEPTH),
    .RES_CREDITS (RES_CREDITS)
  ) DUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_op_i     (cmd_op_i),
    .cmd_a_i      (cmd_a_i),
    .cmd_b_i      (cmd_b_i),
    .cmd_tag_i    (cmd_tag_i),
    .cmd_credit_o (cmd_credit_o),
    .res_valid_o  (res_valid_o),
    .res_data_o   (res_data_o),
    .res_cmp_o    (res_cmp_o),
    .res_tag_o    (res_tag_o),
    .res_credit_i (res_credit_i)
  );

  ////////////////////
  // reference model
  ////////////////////

  // expected result from op rules, tag filled in by the caller
  function automatic exu_res_t ref_result(exu_op_e op, logic [31:0] a, logic [31:0] b);
    exu_res_t           r;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [4:0]         sh;
    logic [63:0]        prod;
    // compare flag on top, compare bit below
    logic [1:0]         cmp;
    sa   = a;
    sb   = b;
    sh   = b[4:0];
    prod = {32'd0, a} * {32'd0, b};
    r    = '0;
    cmp  = 2'b00;
    case (op)
      EXU_ADD:           r.data = a + b;
      EXU_SUB:           r.data = a - b;
      EXU_XOR:           r.data = a ^ b;
      EXU_OR:            r.data = a | b;
      EXU_AND:           r.data = a & b;
      EXU_SLL:           r.data = a << sh;
      EXU_SRL:           r.data = a >> sh;
      EXU_SRA:           r.data = sa >>> sh;
      EXU_MUL:           r.data = prod[31:0];
      EXU_LT, EXU_SLT:   cmp = {1'b1, (sa < sb)};
      EXU_LTU, EXU_SLTU: cmp = {1'b1, (a < b)};
      EXU_GE:            cmp = {1'b1, (sa >= sb)};
      EXU_GEU:           cmp = {1'b1, (a >= b)};
      EXU_EQ:            cmp = {1'b1, (a == b)};
      EXU_NE:            cmp = {1'b1, (a != b)};
      EXU_SLET:          cmp = {1'b1, (sa <= sb)};
      EXU_SLETU:         cmp = {1'b1, (a <= b)};
      default:           ;
    endcase
    // compare bit zero-extended into data
    if (cmp[1]) begin
      r.cmp  = cmp[0];
      r.data = {31'd0, cmp[0]};
    end
    return r;
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic check_res(string name, exu_res_t exp, exu_res_t act);
    checks++;
    if (act !== exp) begin
      $display("Fail %s: expected data=%h cmp=%b tag=%h, actual data=%h cmp=%b tag=%h",
               name, exp.data, exp.cmp, exp.tag, act.data, act.cmp, act.tag);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_count(string what, int exp, int act);
    checks++;
    if (act != exp) begin
      $display("Fail %s: %s expected %0d actual %0d", cur_test, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  // sender credits still held
  function automatic int cmd_avail();
    return CMD_DEPTH - (sent_count - returned_count);
  endfunction

  // outputs are stable at the falling edge
  always @(negedge clk) begin : monitor
    exu_res_t act;
    exu_res_t exp;
    if (rst_n_i) begin
      if (cmd_credit_o) returned_count++;
      if (res_valid_o) begin
        act.data = res_data_o;
        act.cmp  = res_cmp_o;
        act.tag  = res_tag_o;
        res_count++;
        pending_credits++;
        if (exp_q.size() == 0) begin
          $display("%s: result with tag %0d arrived when none was expected",
                   cur_test, res_tag_o);
          errors++;
          test_errors++;
        end else begin
          exp = exp_q.pop_front();
          check_res(cur_test, exp, act);
        end
      end
    end
  end

  // hand result credits back one per cycle unless withheld
  always @(posedge clk) begin
    #1;
    if (!hold_credits && pending_credits > 0) begin
      res_credit_i = 1'b1;
      pending_credits--;
    end else begin
      res_credit_i = 1'b0;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  // called at posedge + 1, drives one command for the coming edge
  task automatic drive_cmd(exu_op_e op, logic [31:0] a, logic [31:0] b);
    exu_res_t exp;
    exp         = ref_result(op, a, b);
    exp.tag     = tag_ctr;
    cmd_valid_i = 1'b1;
    cmd_op_i    = op;
    cmd_a_i     = a;
    cmd_b_i     = b;
    cmd_tag_i   = tag_ctr;
    exp_q.push_back(exp);
    tag_ctr     = tag_ctr + 4'd1;
    sent_count++;
    if (sent_count - returned_count > max_outstanding) begin
      max_outstanding = sent_count - returned_count;
    end
  endtask

  task automatic send_cmd(exu_op_e op, logic [31:0] a, logic [31:0] b);
    while (cmd_avail() == 0) begin
      @(posedge clk);
      #1;
    end
    drive_cmd(op, a, b);
    @(posedge clk);
    #1;
    cmd_valid_i = 1'b0;
  endtask

  // all results in, all result credits handed back
  task automatic wait_drain();
    while (exp_q.size() != 0 || pending_credits != 0) begin
      @(posedge clk);
      #1;
    end
    // credit is added one cycle after its pulse
    @(posedge clk);
    #1;
  endtask

  task automatic start_test(string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    wait_drain();
    test_count++;
    if (test_errors == 0) $display("test %s: ok", cur_test);
    else $display("test %s: %0d errors", cur_test, test_errors);
  endtask

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin : main
    logic [31:0] a;
    logic [31:0] b;
    exu_op_e     op;
    int          bp_sent;
    int          snap;
    rst_n_i     = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_op_i    = EXU_ADD;
    cmd_a_i     = '0;
    cmd_b_i     = '0;
    cmd_tag_i   = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    check_count("res_valid_o after reset", 0, int'(res_valid_o));
    check_count("cmd_credit_o after reset", 0, int'(cmd_credit_o));

    // logic, add, sub, shifts incl. amounts 0 and 31
    start_test("logic_arith_shift");
    send_cmd(EXU_ADD, 32'd5, 32'd7);
    send_cmd(EXU_ADD, 32'hFFFF_FFFF, 32'd1);
    send_cmd(EXU_SUB, 32'd3, 32'd5);
    send_cmd(EXU_SUB, 32'h8000_0000, 32'd1);
    send_cmd(EXU_XOR, 32'hA5A5_F0F0, 32'h0FF0_1234);
    send_cmd(EXU_OR, 32'hA5A5_0000, 32'h0000_5A5A);
    send_cmd(EXU_AND, 32'hDEAD_BEEF, 32'h0F0F_F0F0);
    send_cmd(EXU_SLL, 32'h8000_0001, 32'd0);
    send_cmd(EXU_SLL, 32'h0000_0003, 32'd31);
    send_cmd(EXU_SLL, 32'h0000_0001, 32'hFFFF_FFE5);
    send_cmd(EXU_SRL, 32'h8000_0000, 32'd31);
    send_cmd(EXU_SRA, 32'h8000_0000, 32'd31);
    send_cmd(EXU_SRA, 32'hF000_0000, 32'd4);
    send_cmd(EXU_SRA, 32'h9234_5678, 32'd0);
    end_test();

    start_test("compare");
    for (int p = 0; p < 4; p++) begin
      for (int k = 0; k < 10; k++) send_cmd(cmp_ops[k], pair_a[p], pair_b[p]);
    end
    end_test();

    // overflowing operands keep only the low word
    start_test("multiply");
    send_cmd(EXU_MUL, 32'd0, 32'h1234_5678);
    send_cmd(EXU_MUL, 32'd1, 32'hCAFE_F00D);
    send_cmd(EXU_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    send_cmd(EXU_MUL, 32'hFFFF_FFFF, 32'd5);
    send_cmd(EXU_MUL, 32'h1234_5678, 32'h9ABC_DEF0);
    send_cmd(EXU_MUL, 32'h8000_0000, 32'd2);
    send_cmd(EXU_MUL, 32'hFFFF_0001, 32'h0001_FFFF);
    for (int i = 0; i < 50; i++) begin
      a = $random(seed);
      b = $random(seed);
      send_cmd(EXU_MUL, a, b);
    end
    end_test();

    start_test("random_mix");
    for (int i = 0; i < 200; i++) begin
      op = exu_op_e'(5'($unsigned($random(seed)) % 32'd19));
      a  = $random(seed);
      b  = $random(seed);
      // hit the equal case now and then
      if (($random(seed) & 7) == 0) b = a;
      send_cmd(op, a, b);
    end
    end_test();

    // withhold result credits, queue must fill and input credits stop
    start_test("backpressure");
    @(negedge clk);
    hold_credits = 1'b1;
    @(posedge clk);
    #1;
    snap    = res_count;
    bp_sent = 0;
    repeat (100) begin
      if (cmd_avail() > 0 && bp_sent < BP_TOTAL) begin
        a = $random(seed);
        b = $random(seed);
        drive_cmd((bp_sent % 3 == 0) ? EXU_MUL : EXU_SUB, a, b);
        bp_sent++;
      end else begin
        cmd_valid_i = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    cmd_valid_i = 1'b0;
    checks++;
    if (res_count - snap > RES_CREDITS) begin
      $display("%s: %0d results came out while credits were withheld",
               cur_test, res_count - snap);
      errors++;
      test_errors++;
    end
    check_count("commands accepted while held", CMD_DEPTH + RES_CREDITS, bp_sent);
    check_count("input credits while held", 0, cmd_avail());
    @(negedge clk);
    hold_credits = 1'b0;
    @(posedge clk);
    #1;
    while (bp_sent < BP_TOTAL) begin
      a = $random(seed);
      b = $random(seed);
      send_cmd(EXU_ADD, a, b);
      bp_sent++;
    end
    wait_drain();
    check_count("results delivered", BP_TOTAL, res_count - snap);
    end_test();

    start_test("credit_accounting");
    check_count("cmd_credit_o pulses vs commands", sent_count, returned_count);
    check_count("sender credits at rest", CMD_DEPTH, cmd_avail());
    // queue filled under back-pressure, never beyond its depth
    check_count("peak outstanding commands", CMD_DEPTH, max_outstanding);
    end_test();

    $display("%0d tests, %0d checks, %0d results, %0d errors",
             test_count, checks, res_count, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
